/* dv/acq_tb.sv */
`timescale 1ns/1ns
`include "acq_defs.svh"

module acq_tb;

   // Table operations
   localparam logic [2:0] OP_WR       = 3'd0;
   localparam logic [2:0] OP_RD       = 3'd1;
   localparam logic [2:0] OP_CTRL     = 3'd2;
   localparam logic [2:0] OP_BS       = 3'd3;
   localparam logic [2:0] OP_SPI      = 3'd4;
   localparam logic [2:0] OP_NEWBLK   = 3'd5;
   localparam logic [2:0] OP_STREAMED = 3'd6;
   localparam logic [2:0] OP_VX       = 3'd7;

   typedef struct packed {
      logic [2:0]         test;
      logic [2:0]         op;
      acq_pkg::reg_addr_t adr;
      acq_pkg::bus_data_t dat;
      logic [31:0]        exp;
      logic [31:0]        mask;
   } step_t;

   logic                clk;
   logic                rst;
   acq_pkg::bus_req_t   req;
   logic                ack;
   acq_pkg::bus_data_t  rdata;
   logic                data_ready;
   logic                data_request;
   acq_pkg::sample_t    sample;
   logic                spi_busy;
   logic                vx_cyc;
   logic                vx_stb;
   logic                vx_ack;
   acq_pkg::bus_data_t  vx_dat;
   logic                overflow;
   logic                newblock;
   logic                streamed;
   logic                vx_stuck;
   logic                vx_limp;
   acq_pkg::dram_adr_t  aq_adr;
   acq_pkg::acq_ctrl_t  ctrl;
   acq_pkg::vx_state_t  vx_state;
   acq_pkg::blocksize_t blocksize;

   step_t steps [0:63];
   int    n_steps;
   int    fill_group;
   int    run_group;
   int    checks;
   int    errors;
   int    group_checks;
   int    group_errors;
   logic  timed_out;
   // vx_cyc as seen while the last request was held
   logic  cyc_seen;

   acq_top dut0 (
      .clk_i(clk), .rst_i(rst), .req_i(req), .ack_o(ack), .dat_o(rdata),
      .data_ready_i(data_ready), .data_request_o(data_request), .data_i(sample),
      .spi_busy_i(spi_busy), .vx_cyc_o(vx_cyc), .vx_stb_o(vx_stb), .vx_ack_i(vx_ack),
      .vx_dat_i(vx_dat), .overflow_i(overflow), .newblock_i(newblock),
      .streamed_i(streamed), .vx_stuck_i(vx_stuck), .vx_limp_i(vx_limp),
      .aq_adr_i(aq_adr), .ctrl_o(ctrl), .vx_o(vx_state), .blocksize_o(blocksize)
   );

   acq_tb_models models0 (
      .clk_i(clk), .rst_i(rst), .data_request_i(data_request),
      .data_ready_o(data_ready), .data_o(sample), .vx_stb_i(vx_stb),
      .vx_ack_o(vx_ack), .vx_dat_o(vx_dat), .blk_i(vx_state.vx_blk)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic string group_name(input int g);
      case (g)
         1:       return "reset state";
         2:       return "register read-back";
         3:       return "block size";
         4:       return "sample stream";
         default: return "visibilities";
      endcase
   endfunction

   task automatic add_step(input logic [2:0] op, input acq_pkg::reg_addr_t adr,
                           input acq_pkg::bus_data_t dat, input logic [31:0] exp,
                           input logic [31:0] mask);
      steps[n_steps] = {fill_group[2:0], op, adr, dat, exp, mask};
      n_steps = n_steps + 1;
   endtask

   //------------------------------------------------------------
   // Stimulus and expected values
   //------------------------------------------------------------
   task automatic build_table();
      fill_group = 1;
      add_step(OP_RD, `AQ_SYSTEM, 8'h00, 32'h00, 32'hff);
      add_step(OP_RD, `VX_SYSTEM, 8'h00, 32'h00, 32'hff);
      add_step(OP_RD, `VX_STATUS, 8'h00, 32'h00, 32'hff);
      add_step(OP_CTRL, 4'h0, 8'h00, 32'h00, 32'h7f);
      add_step(OP_BS, 4'h0, 8'h00, 32'h0, 32'hffff_ffff);
      // Visibility state in bits 11:0, vx_cyc of the last transfer in bit 12
      add_step(OP_VX, 4'h0, 8'h00, 32'h0, 32'hfff);
      fill_group = 2;
      // Unused bits of each register are dropped
      add_step(OP_WR, `AQ_SYSTEM, 8'hfd, 32'h0, 32'h0);
      add_step(OP_RD, `AQ_SYSTEM, 8'h00, 32'h85, 32'hff);
      add_step(OP_WR, `AQ_DEBUG, 8'h80, 32'h0, 32'h0);
      add_step(OP_RD, `AQ_DEBUG, 8'h00, 32'h80, 32'hff);
      add_step(OP_WR, `VX_SYSTEM, 8'he3, 32'h0, 32'h0);
      add_step(OP_RD, `VX_SYSTEM, 8'h00, 32'hc3, 32'hff);
      add_step(OP_CTRL, 4'h0, 8'h00, 32'h77, 32'h7f);
      add_step(OP_WR, `AQ_SYSTEM, 8'h02, 32'h0, 32'h0);
      add_step(OP_RD, `AQ_SYSTEM, 8'h00, 32'h02, 32'hff);
      add_step(OP_CTRL, 4'h0, 8'h00, 32'h2b, 32'h7f);
      fill_group = 3;
      add_step(OP_WR, `VX_SYSTEM, 8'hc0, 32'h0, 32'h0);
      add_step(OP_BS, 4'h0, 8'h00, 32'h0, 32'hffff_ffff);
      add_step(OP_WR, `VX_SYSTEM, 8'hc5, 32'h0, 32'h0);
      add_step(OP_BS, 4'h0, 8'h00, 32'h1f, 32'hffff_ffff);
      add_step(OP_WR, `VX_SYSTEM, 8'hd7, 32'h0, 32'h0);
      add_step(OP_BS, 4'h0, 8'h00, 32'h7f_ffff, 32'hffff_ffff);
      // Exponent 30 saturates at 24 bits
      add_step(OP_WR, `VX_SYSTEM, 8'hde, 32'h0, 32'h0);
      add_step(OP_BS, 4'h0, 8'h00, 32'hff_ffff, 32'hffff_ffff);
      add_step(OP_RD, `VX_SYSTEM, 8'h00, 32'hde, 32'hff);
      fill_group = 4;
      add_step(OP_SPI, 4'h0, 8'h01, 32'h0, 32'h0);
      // Samples 0, 1 and 2, MSB first
      add_step(OP_RD, `AX_STREAM, 8'h00, 32'h0a, 32'hff);
      add_step(OP_RD, `AX_STREAM, 8'h00, 32'h0b, 32'hff);
      add_step(OP_RD, `AX_STREAM, 8'h00, 32'h0c, 32'hff);
      add_step(OP_RD, `AX_STREAM, 8'h00, 32'h0b, 32'hff);
      add_step(OP_RD, `AX_STREAM, 8'h00, 32'h0d, 32'hff);
      add_step(OP_RD, `AX_STREAM, 8'h00, 32'h0f, 32'hff);
      add_step(OP_RD, `AX_STREAM, 8'h00, 32'h0c, 32'hff);
      add_step(OP_RD, `AX_STREAM, 8'h00, 32'h0f, 32'hff);
      add_step(OP_RD, `AX_STREAM, 8'h00, 32'h12, 32'hff);
      // Head is now sample 3
      add_step(OP_RD, `AX_DATA1, 8'h00, 32'h0d, 32'hff);
      add_step(OP_RD, `AX_DATA2, 8'h00, 32'h11, 32'hff);
      add_step(OP_RD, `AX_DATA3, 8'h00, 32'h15, 32'hff);
      add_step(OP_RD, `AX_STREAM, 8'h00, 32'h0d, 32'hff);
      add_step(OP_SPI, 4'h0, 8'h00, 32'h0, 32'h0);
      add_step(OP_SPI, 4'h0, 8'h01, 32'h0, 32'h0);
      add_step(OP_RD, `AX_STREAM, 8'h00, 32'h0d, 32'hff);
      fill_group = 5;
      add_step(OP_NEWBLK, 4'h0, 8'h00, 32'h0, 32'h0);
      add_step(OP_VX, 4'h0, 8'h00, 32'h5e, 32'hfff);
      add_step(OP_RD, `VX_STATUS, 8'h00, 32'h80, 32'hff);
      add_step(OP_RD, `VX_STREAM, 8'h00, 32'hc0, 32'hff);
      // Stream read forwarded with vx_cyc high
      add_step(OP_VX, 4'h0, 8'h00, 32'h103e, 32'h1fff);
      add_step(OP_RD, `VX_STATUS, 8'h00, 32'h40, 32'hff);
      add_step(OP_STREAMED, 4'h0, 8'h00, 32'h0, 32'h0);
      add_step(OP_STREAMED, 4'h0, 8'h00, 32'h0, 32'h0);
      add_step(OP_RD, `VX_STATUS, 8'h00, 32'h42, 32'hff);
      add_step(OP_RD, `VX_STREAM, 8'h00, 32'hc2, 32'hff);
      add_step(OP_WR, `VX_STATUS, 8'h07, 32'h0, 32'h0);
      add_step(OP_RD, `VX_STATUS, 8'h00, 32'h47, 32'hff);
      add_step(OP_RD, `VX_STREAM, 8'h00, 32'hc7, 32'hff);
      add_step(OP_VX, 4'h0, 8'h00, 32'h13be, 32'h1fff);
   endtask

   //------------------------------------------------------------
   // Bus transfer, held until ack then one idle cycle
   //------------------------------------------------------------
   task automatic bus_transfer(input logic we, input acq_pkg::reg_addr_t adr,
                               input acq_pkg::bus_data_t dat,
                               output acq_pkg::bus_data_t got);
      int waited;
      waited = 0;
      req = {1'b1, 1'b1, we, adr, dat};
      @(posedge clk);
      #1;
      while (!ack && waited < 50) begin
         @(posedge clk);
         #1;
         waited = waited + 1;
      end
      if (!ack) begin
         $display("no acknowledge from DUT at %0t for address %h", $time, adr);
         timed_out = 1'b1;
      end
      got      = rdata;
      cyc_seen = vx_cyc;
      req = '0;
      @(posedge clk);
      #1;
   endtask

   task automatic check_value(input int idx, input logic [31:0] got, input step_t s);
      checks       = checks + 1;
      group_checks = group_checks + 1;
      assert ((got & s.mask) == (s.exp & s.mask)) else begin
         $display("FAIL %0t: step %0d adr %h got %h expected %h", $time, idx, s.adr,
                  got & s.mask, s.exp & s.mask);
         errors       = errors + 1;
         group_errors = group_errors + 1;
      end
   endtask

   task automatic report_group();
      $display("test %0d %s: %0d checks, %0d failed", run_group, group_name(run_group),
               group_checks, group_errors);
      group_checks = 0;
      group_errors = 0;
   endtask

   initial begin : main
      step_t              s;
      acq_pkg::bus_data_t rd;
      int                 i;
      req          = '0;
      spi_busy     = 1'b0;
      overflow     = 1'b0;
      newblock     = 1'b0;
      streamed     = 1'b0;
      vx_stuck     = 1'b0;
      vx_limp      = 1'b0;
      aq_adr       = '0;
      timed_out    = 1'b0;
      cyc_seen     = 1'b0;
      n_steps      = 0;
      checks       = 0;
      errors       = 0;
      group_checks = 0;
      group_errors = 0;
      build_table();
      rst = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      run_group = steps[0].test;
      for (i = 0; i < n_steps && !timed_out; i++) begin
         s = steps[i];
         if (s.test != run_group) begin
            report_group();
            run_group = s.test;
         end
         case (s.op)
            OP_WR: bus_transfer(1'b1, s.adr, s.dat, rd);
            OP_RD: begin
               bus_transfer(1'b0, s.adr, 8'h00, rd);
               check_value(i, {24'h0, rd}, s);
            end
            OP_CTRL: check_value(i, {25'h0, ctrl}, s);
            OP_BS: begin
               // Block size settles two cycles after the write
               repeat (2) @(posedge clk);
               #1;
               check_value(i, blocksize, s);
            end
            OP_SPI: begin
               spi_busy = s.dat[0];
               @(posedge clk);
               #1;
            end
            OP_NEWBLK: begin
               newblock = 1'b1;
               @(posedge clk);
               #1;
               newblock = 1'b0;
            end
            OP_VX: check_value(i, {19'h0, cyc_seen, vx_state}, s);
            default: begin
               streamed = 1'b1;
               @(posedge clk);
               #1;
               streamed = 1'b0;
            end
         endcase
      end
      report_group();
      $display("%0d checks, %0d failed", checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* dv/acq_tb_models.sv */
`timescale 1ns/1ns

module acq_tb_models (
   input  logic               clk_i,
   input  logic               rst_i,
   // DRAM sample reader side
   input  logic               data_request_i,
   output logic               data_ready_o,
   output acq_pkg::sample_t   data_o,
   // Visibility unit bus side
   input  logic               vx_stb_i,
   output logic               vx_ack_o,
   output acq_pkg::bus_data_t vx_dat_o,
   input  acq_pkg::blk_t      blk_i
);

   int   n_answered;
   int   dram_wait;
   int   vx_wait;
   logic req_seen;
   logic dram_rst;
   logic stb_seen;
   logic ack_seen;

   initial begin
      data_ready_o = 1'b0;
      data_o       = '0;
      vx_ack_o     = 1'b0;
      vx_dat_o     = '0;
      n_answered   = 0;
      dram_wait    = 0;
      vx_wait      = 0;
   end

   //------------------------------------------------------------
   // DRAM source, answers 3 cycles after each request
   //------------------------------------------------------------
   always @(posedge clk_i) begin
      req_seen = data_request_i;
      dram_rst = rst_i;
      #1;
      data_ready_o = 1'b0;
      if (dram_rst) begin
         n_answered = 0;
         dram_wait  = 0;
      end else if (req_seen) begin
         dram_wait = 3;
      end else if (dram_wait > 0) begin
         dram_wait = dram_wait - 1;
         if (dram_wait == 0) begin
            // Sample n is n * 0x010203 + 0x0A0B0C
            data_ready_o = 1'b1;
            data_o       = 24'(n_answered * 32'h010203 + 32'h0A0B0C);
            n_answered   = n_answered + 1;
         end
      end
   end

   //------------------------------------------------------------
   // Visibility responder, ack two cycles into the request
   //------------------------------------------------------------
   always @(posedge clk_i) begin
      stb_seen = vx_stb_i;
      ack_seen = vx_ack_o;
      #1;
      if (ack_seen) begin
         vx_ack_o = 1'b0;
         vx_wait  = 0;
      end else if (stb_seen) begin
         vx_wait = vx_wait + 1;
         if (vx_wait == 2) begin
            vx_ack_o = 1'b1;
            vx_dat_o = 8'hc0 + 8'(blk_i);
         end
      end
   end

endmodule

/* hw/acq_bus_slave.sv */
`timescale 1ns/1ns
`include "acq_defs.svh"

module acq_bus_slave (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  acq_pkg::bus_req_t    req_i,
   output logic                 ack_o,
   output acq_pkg::bus_data_t   dat_o,
   output acq_pkg::bus_access_t access_o,
   output logic                 ax_take_o,
   output logic                 x_done_o,
   input  acq_pkg::bus_data_t   ax_byte_i,
   input  acq_pkg::sample_t     ax_sample_i,
   input  acq_pkg::acq_ctrl_t   ctrl_i,
   input  acq_pkg::vx_state_t   vx_i,
   input  logic                 overflow_i,
   input  logic                 vx_stuck_i,
   input  logic                 vx_limp_i,
   input  acq_pkg::dram_adr_t   aq_adr_i,
   output logic                 vx_cyc_o,
   output logic                 vx_stb_o,
   input  logic                 vx_ack_i,
   input  acq_pkg::bus_data_t   vx_dat_i
);

   logic               accept;
   logic               is_vx;
   acq_pkg::bus_data_t rd_word;

   // Classic transfers: no new request while ack is out
   assign accept = req_i.cyc && req_i.stb && !ack_o;
   assign is_vx  = req_i.adr == `VX_STREAM;

   //------------------------------------------------------------
   // Visibility unit bus, request passed straight through
   //------------------------------------------------------------
   assign vx_cyc_o = req_i.cyc;
   assign vx_stb_o = accept && is_vx;

   // Stream read finishes when the visibility unit answers
   assign x_done_o = accept && is_vx && !req_i.we && vx_ack_i;

   //------------------------------------------------------------
   // Strobes towards settings and prefetcher
   //------------------------------------------------------------
   // Stream writes go nowhere, so keep them off the settings path
   assign access_o.wr  = accept && req_i.we && !is_vx;
   assign access_o.adr = req_i.adr;
   assign access_o.dat = req_i.dat;

   assign ax_take_o = accept && !req_i.we && req_i.adr == `AX_STREAM;

   //------------------------------------------------------------
   // Acknowledge, one cycle after acceptance or after vx_ack_i
   //------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= accept && (!is_vx || vx_ack_i);
      end
   end

   // Read word selection
   always_comb begin
      case (req_i.adr)
         `AX_STREAM: rd_word = ax_byte_i;
         `AX_DATA1:  rd_word = ax_sample_i[23:16];
         `AX_DATA2:  rd_word = ax_sample_i[15:8];
         `AX_DATA3:  rd_word = ax_sample_i[7:0];
         // Low byte of the acquisition write address
         `AQ_STATUS: rd_word = aq_adr_i[7:0];
         `AQ_DEBUG:  rd_word = {ctrl_i.aq_debug_mode, vx_stuck_i, vx_limp_i, 5'b0};
         `AQ_SYSTEM: rd_word = {ctrl_i.aq_enabled, 4'b0, ctrl_i.aq_sample_delay};
         `VX_STREAM: rd_word = vx_dat_i;
         `VX_STATUS: rd_word = {vx_i.available, vx_i.accessed, overflow_i,
                                5'(vx_i.vx_blk)};
         `VX_SYSTEM: rd_word = {ctrl_i.vx_enabled, ctrl_i.vx_overwrite, 1'b0,
                                vx_i.log_block};
         default:    rd_word = 8'h00;
      endcase
   end

   // Captured while the request waits, last value goes out with ack
   always_ff @(posedge clk_i) begin
      if (accept && !req_i.we) begin
         dat_o <= rd_word;
      end
   end

endmodule

/* hw/acq_defs.svh */
`ifndef ACQ_DEFS_SVH
`define ACQ_DEFS_SVH

//------------------------------------------------------------
// Register map of the acquisition unit
//------------------------------------------------------------

// Raw antenna data, streamed or by byte
`define AX_STREAM 4'h0
`define AX_DATA1  4'h1
`define AX_DATA2  4'h2
`define AX_DATA3  4'h3

// Acquisition status and control
`define AQ_STATUS 4'h4
`define AQ_DEBUG  4'h6
`define AQ_SYSTEM 4'h7

// Visibility stream, status and control
`define VX_STREAM 4'h8
`define VX_STATUS 4'h9
`define VX_SYSTEM 4'ha

// Number of stored visibility blocks is 2**BLOCK_BITS
`define BLOCK_BITS 5

// One antenna sample, three bus bytes
`define SAMPLE_BITS 24

`endif

/* hw/acq_pkg.sv */
`include "acq_defs.svh"

package acq_pkg;

   //------------------------------------------------------------
   // Widths with a meaning
   //------------------------------------------------------------
   typedef logic [3:0]              reg_addr_t;
   typedef logic [7:0]              bus_data_t;
   typedef logic [`SAMPLE_BITS-1:0] sample_t;
   typedef logic [`BLOCK_BITS-1:0]  blk_t;
   typedef logic [4:0]              log_blk_t;
   // Visibilities per block minus one
   typedef logic [31:0]             blocksize_t;
   typedef logic [24:0]             dram_adr_t;

   //------------------------------------------------------------
   // Grouped signals
   //------------------------------------------------------------
   // Host request, classic transfers only
   typedef struct packed {
      logic      cyc;
      logic      stb;
      logic      we;
      reg_addr_t adr;
      bus_data_t dat;
   } bus_req_t;

   // One-cycle write strobe towards the settings block
   typedef struct packed {
      logic      wr;
      reg_addr_t adr;
      bus_data_t dat;
   } bus_access_t;

   typedef struct packed {
      logic       aq_enabled;
      logic       aq_debug_mode;
      logic [2:0] aq_sample_delay;
      logic       vx_enabled;
      logic       vx_overwrite;
   } acq_ctrl_t;

   typedef struct packed {
      blk_t     vx_blk;
      logic     available;
      logic     accessed;
      log_blk_t log_block;
   } vx_state_t;

   // Count of buffered samples
   typedef enum logic [1:0] {
      PF_EMPTY,
      PF_ONE,
      PF_TWO
   } pf_state_e;

endpackage

/* hw/acq_settings.sv */
`timescale 1ns/1ns
`include "acq_defs.svh"

module acq_settings (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  acq_pkg::bus_access_t access_i,
   input  logic                 x_done_i,
   input  logic                 newblock_i,
   input  logic                 streamed_i,
   output acq_pkg::acq_ctrl_t   ctrl_o,
   output acq_pkg::vx_state_t   vx_o,
   output acq_pkg::blocksize_t  blocksize_o
);

   acq_pkg::log_blk_t log_block;
   acq_pkg::blk_t     vx_blk;
   acq_pkg::blk_t     new_blk;
   logic              upd_blk;
   logic              bs_upd;
   logic              available;
   logic              accessed;

   // 2**lb - 1, capped at 24 bits
   function automatic acq_pkg::blocksize_t bs_lookup(input acq_pkg::log_blk_t lb);
      acq_pkg::blocksize_t bs;
      if (lb >= 5'd24) begin
         bs = 32'h00ff_ffff;
      end else begin
         bs = (32'd1 << lb) - 32'd1;
      end
      return bs;
   endfunction

   //------------------------------------------------------------
   // Control registers
   //------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ctrl_o    <= '0;
         log_block <= '0;
      end else if (access_i.wr) begin
         case (access_i.adr)
            `AQ_DEBUG: begin
               ctrl_o.aq_debug_mode <= access_i.dat[7];
            end
            `AQ_SYSTEM: begin
               ctrl_o.aq_enabled      <= access_i.dat[7];
               ctrl_o.aq_sample_delay <= access_i.dat[2:0];
            end
            `VX_SYSTEM: begin
               ctrl_o.vx_enabled   <= access_i.dat[7];
               ctrl_o.vx_overwrite <= access_i.dat[6];
               log_block           <= access_i.dat[4:0];
            end
            default: begin
            end
         endcase
      end
   end

   //------------------------------------------------------------
   // Block size, one cycle behind the exponent
   //------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bs_upd      <= 1'b0;
         blocksize_o <= '0;
      end else begin
         bs_upd <= access_i.wr && access_i.adr == `VX_SYSTEM;
         if (bs_upd) begin
            blocksize_o <= bs_lookup(log_block);
         end
      end
   end

   //------------------------------------------------------------
   // Visibility block counter
   //------------------------------------------------------------
   // Host-written block number, applied a cycle later
   always_ff @(posedge clk_i) begin
      if (access_i.wr && access_i.adr == `VX_STATUS) begin
         new_blk <= access_i.dat[`BLOCK_BITS-1:0];
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         upd_blk <= 1'b0;
         vx_blk  <= '0;
      end else begin
         upd_blk <= access_i.wr && access_i.adr == `VX_STATUS;
         // Host load wins over a streamed block
         if (upd_blk) begin
            vx_blk <= new_blk;
         end else if (streamed_i) begin
            vx_blk <= vx_blk + 1'b1;
         end
      end
   end

   // Block flags, a new block overrides a finished read
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         available <= 1'b0;
         accessed  <= 1'b0;
      end else if (newblock_i) begin
         available <= 1'b1;
         accessed  <= 1'b0;
      end else if (x_done_i) begin
         available <= 1'b0;
         accessed  <= 1'b1;
      end
   end

   assign vx_o.vx_blk    = vx_blk;
   assign vx_o.available = available;
   assign vx_o.accessed  = accessed;
   assign vx_o.log_block = log_block;

endmodule

/* hw/acq_top.sv */
`timescale 1ns/1ns

module acq_top (
   input  logic                clk_i,
   input  logic                rst_i,
   // Host register bus
   input  acq_pkg::bus_req_t   req_i,
   output logic                ack_o,
   output acq_pkg::bus_data_t  dat_o,
   // DRAM sample reader
   input  logic                data_ready_i,
   output logic                data_request_o,
   input  acq_pkg::sample_t    data_i,
   input  logic                spi_busy_i,
   // Visibility unit bus and status
   output logic                vx_cyc_o,
   output logic                vx_stb_o,
   input  logic                vx_ack_i,
   input  acq_pkg::bus_data_t  vx_dat_i,
   input  logic                overflow_i,
   input  logic                newblock_i,
   input  logic                streamed_i,
   input  logic                vx_stuck_i,
   input  logic                vx_limp_i,
   input  acq_pkg::dram_adr_t  aq_adr_i,
   // Settings out
   output acq_pkg::acq_ctrl_t  ctrl_o,
   output acq_pkg::vx_state_t  vx_o,
   output acq_pkg::blocksize_t blocksize_o
);

   acq_pkg::bus_access_t access;
   acq_pkg::bus_data_t   ax_byte;
   acq_pkg::sample_t     ax_sample;
   logic                 ax_take;
   logic                 x_done;

   //------------------------------------------------------------
   // Bus side, settings, prefetcher
   //------------------------------------------------------------
   acq_bus_slave bus0 (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_i      (req_i),
      .ack_o      (ack_o),
      .dat_o      (dat_o),
      .access_o   (access),
      .ax_take_o  (ax_take),
      .x_done_o   (x_done),
      .ax_byte_i  (ax_byte),
      .ax_sample_i(ax_sample),
      .ctrl_i     (ctrl_o),
      .vx_i       (vx_o),
      .overflow_i (overflow_i),
      .vx_stuck_i (vx_stuck_i),
      .vx_limp_i  (vx_limp_i),
      .aq_adr_i   (aq_adr_i),
      .vx_cyc_o   (vx_cyc_o),
      .vx_stb_o   (vx_stb_o),
      .vx_ack_i   (vx_ack_i),
      .vx_dat_i   (vx_dat_i)
   );

   acq_settings set0 (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .access_i   (access),
      .x_done_i   (x_done),
      .newblock_i (newblock_i),
      .streamed_i (streamed_i),
      .ctrl_o     (ctrl_o),
      .vx_o       (vx_o),
      .blocksize_o(blocksize_o)
   );

   sample_prefetch pf0 (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .spi_busy_i    (spi_busy_i),
      .ax_take_i     (ax_take),
      .data_ready_i  (data_ready_i),
      .data_request_o(data_request_o),
      .data_i        (data_i),
      .sample_o      (ax_sample),
      .byte_o        (ax_byte)
   );

endmodule

/* hw/sample_prefetch.sv */
`timescale 1ns/1ns
`include "acq_defs.svh"

module sample_prefetch (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               spi_busy_i,
   input  logic               ax_take_i,
   input  logic               data_ready_i,
   output logic               data_request_o,
   input  acq_pkg::sample_t   data_i,
   output acq_pkg::sample_t   sample_o,
   output acq_pkg::bus_data_t byte_o
);

   acq_pkg::pf_state_e state;
   acq_pkg::sample_t   head;
   acq_pkg::sample_t   tail;
   logic               pending;
   logic               req_go;
   logic               retire;
   logic [1:0]         index;

   // Ask for more while there is room and nothing in flight
   assign req_go = state != acq_pkg::PF_TWO && !pending;
   // Third byte taken, drop the head unless the buffer is empty
   assign retire = ax_take_i && index == 2'd2 && state != acq_pkg::PF_EMPTY;

   //------------------------------------------------------------
   // DRAM request strobe
   //------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         data_request_o <= 1'b0;
         pending        <= 1'b0;
      end else begin
         data_request_o <= req_go;
         if (req_go) begin
            pending <= 1'b1;
         end else if (data_ready_i) begin
            pending <= 1'b0;
         end
      end
   end

   //------------------------------------------------------------
   // Two-entry sample buffer
   //------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= acq_pkg::PF_EMPTY;
      end else begin
         case (state)
            acq_pkg::PF_EMPTY: begin
               if (data_ready_i) begin
                  head  <= data_i;
                  state <= acq_pkg::PF_ONE;
               end
            end
            acq_pkg::PF_ONE: begin
               // Arrival and retire together, new sample becomes the head
               if (data_ready_i && retire) begin
                  head <= data_i;
               end else if (data_ready_i) begin
                  tail  <= data_i;
                  state <= acq_pkg::PF_TWO;
               end else if (retire) begin
                  state <= acq_pkg::PF_EMPTY;
               end
            end
            default: begin
               // Full, so no request can be outstanding here
               if (retire) begin
                  head  <= tail;
                  state <= acq_pkg::PF_ONE;
               end
            end
         endcase
      end
   end

   // Byte index, restarts whenever the SPI side goes idle
   always_ff @(posedge clk_i) begin
      if (rst_i || !spi_busy_i) begin
         index <= 2'd0;
      end else if (ax_take_i) begin
         index <= index == 2'd2 ? 2'd0 : index + 2'd1;
      end
   end

   assign sample_o = head;

   // MSB first
   always_comb begin
      case (index)
         2'd0:    byte_o = head[`SAMPLE_BITS-1 -: 8];
         2'd1:    byte_o = head[`SAMPLE_BITS-9 -: 8];
         default: byte_o = head[7:0];
      endcase
   end

endmodule

/* tb.f */
+incdir+hw
hw/acq_pkg.sv
hw/acq_bus_slave.sv
hw/acq_settings.sv
hw/sample_prefetch.sv
hw/acq_top.sv
dv/acq_tb_models.sv
dv/acq_tb.sv
